/* source/ntm_arith_pkg.sv */
//////////////////////////////////////////////////
// Vector engine arithmetic package
// Element sizes, operand and configuration bundles
//////////////////////////////////////////////////

`default_nettype none

package ntm_arith_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////

  // Width of one vector element
  localparam int DATA_SIZE = 16;
  // Element index into a buffer
  localparam int INDEX_SIZE = 4;
  // Buffer depth in elements
  localparam int VECTOR_MAX = 16;
  // Length register, holds 0 to VECTOR_MAX
  localparam int SIZE_WIDTH = 5;
  // Multiplier accumulator, room for 2*acc + b below 3*modulo
  localparam int ACC_SIZE = DATA_SIZE + 2;
  // Bit counter of the multiplier
  localparam int STEP_CNT_SIZE = $clog2(DATA_SIZE);

  //////////////////////////////////////////////////
  // Bundles
  //////////////////////////////////////////////////

  // Operands of one scalar multiply
  typedef struct packed {
    logic [DATA_SIZE-1:0] modulo;
    logic [DATA_SIZE-1:0] a;
    logic [DATA_SIZE-1:0] b;
  } mul_op_t;

  // Run configuration from the register block
  typedef struct packed {
    logic [DATA_SIZE-1:0]  modulo;
    logic [SIZE_WIDTH-1:0] size;
  } vec_cfg_t;

endpackage

`default_nettype wire

/* source/ntm_wb_pkg.sv */
//////////////////////////////////////////////////
// Wishbone package of the vector engine
// Bus bundles, address map, control/status word
//////////////////////////////////////////////////

`default_nettype none

package ntm_wb_pkg;

  // Word address and data widths
  localparam int WB_ADR_SIZE = 6;
  localparam int WB_DATA_SIZE = 32;

  //////////////////////////////////////////////////
  // Address map
  //////////////////////////////////////////////////

  localparam logic [WB_ADR_SIZE-1:0] ADR_CTRL   = 6'h00;
  localparam logic [WB_ADR_SIZE-1:0] ADR_MODULO = 6'h01;
  localparam logic [WB_ADR_SIZE-1:0] ADR_SIZE   = 6'h02;
  // Vector regions, 16 words each
  localparam logic [WB_ADR_SIZE-1:0] ADR_A_BASE = 6'h10;
  localparam logic [WB_ADR_SIZE-1:0] ADR_B_BASE = 6'h20;
  localparam logic [WB_ADR_SIZE-1:0] ADR_R_BASE = 6'h30;

  // Master to slave
  typedef struct packed {
    logic                    cyc;
    logic                    stb;
    logic                    we;
    logic [WB_ADR_SIZE-1:0]  adr;
    logic [WB_DATA_SIZE-1:0] dat;
  } wb_req_t;

  // Slave to master
  typedef struct packed {
    logic                    ack;
    logic [WB_DATA_SIZE-1:0] dat;
  } wb_rsp_t;

  // Control word as written
  typedef struct packed {
    logic [WB_DATA_SIZE-2:0] rsvd;
    logic                    start;
  } ctrl_t;

  // Same word as read back
  typedef struct packed {
    logic [WB_DATA_SIZE-3:0] rsvd;
    logic                    done;
    logic                    busy;
  } status_t;

  typedef union packed {
    ctrl_t   ctrl;
    status_t status;
  } ctrl_word_u;

endpackage

`default_nettype wire

/* source/ntm_wb_regs.sv */
//////////////////////////////////////////////////
// Wishbone register and buffer block
// Config registers, A/B/result buffers, done flag
// One wait state classic slave
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module ntm_wb_regs (
  input  wire                                           CLK,
  input  wire                                           RST,
  input  wire ntm_wb_pkg::wb_req_t                      wb_req,
  output ntm_wb_pkg::wb_rsp_t                           wb_rsp,
  output ntm_arith_pkg::vec_cfg_t                       cfg,
  output logic                                          go,
  input  wire                                           busy,
  input  wire                                           finish,
  input  wire logic [ntm_arith_pkg::INDEX_SIZE-1:0]     rd_index,
  output ntm_arith_pkg::mul_op_t                        op,
  input  wire                                           res_we,
  input  wire logic [ntm_arith_pkg::INDEX_SIZE-1:0]     res_index,
  input  wire logic [ntm_arith_pkg::DATA_SIZE-1:0]      res_data
);

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  logic [ntm_arith_pkg::DATA_SIZE-1:0]  modulo_q;
  logic [ntm_arith_pkg::SIZE_WIDTH-1:0] size_q;
  logic                                 done_q;
  logic [ntm_arith_pkg::DATA_SIZE-1:0]  a_mem [ntm_arith_pkg::VECTOR_MAX];
  logic [ntm_arith_pkg::DATA_SIZE-1:0]  b_mem [ntm_arith_pkg::VECTOR_MAX];
  logic [ntm_arith_pkg::DATA_SIZE-1:0]  r_mem [ntm_arith_pkg::VECTOR_MAX];

  // Bus decode
  logic                                 access;
  logic                                 wr_ok;
  logic [ntm_wb_pkg::WB_ADR_SIZE-1:0]   base;
  logic [ntm_arith_pkg::INDEX_SIZE-1:0] word;
  logic [ntm_arith_pkg::SIZE_WIDTH-1:0] size_wr;
  ntm_wb_pkg::ctrl_word_u               wr_word;
  ntm_wb_pkg::ctrl_word_u               rd_status;
  logic [ntm_wb_pkg::WB_DATA_SIZE-1:0]  rd_data;

  // New request, ack not yet given
  assign access = wb_req.cyc & wb_req.stb & ~wb_rsp.ack;
  // Config writes locked from go until the run ends
  assign wr_ok = access & wb_req.we & ~busy & ~go;

  // Region base from upper address bits, word within region
  assign base = {wb_req.adr[ntm_wb_pkg::WB_ADR_SIZE-1:ntm_arith_pkg::INDEX_SIZE],
                 {ntm_arith_pkg::INDEX_SIZE{1'b0}}};
  assign word = wb_req.adr[ntm_arith_pkg::INDEX_SIZE-1:0];

  assign wr_word = wb_req.dat;

  // Lengths above buffer depth saturate
  always_comb begin
    if (wb_req.dat > ntm_arith_pkg::VECTOR_MAX)
      size_wr = (ntm_arith_pkg::SIZE_WIDTH)'(ntm_arith_pkg::VECTOR_MAX);
    else
      size_wr = wb_req.dat[ntm_arith_pkg::SIZE_WIDTH-1:0];
  end

  //////////////////////////////////////////////////
  // Host writes
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      modulo_q <= '0;
      size_q   <= '0;
      for (int i = 0; i < ntm_arith_pkg::VECTOR_MAX; i++) begin
        a_mem[i] <= '0;
        b_mem[i] <= '0;
      end
    end else if (wr_ok) begin
      if (wb_req.adr == ntm_wb_pkg::ADR_MODULO)
        modulo_q <= wb_req.dat[ntm_arith_pkg::DATA_SIZE-1:0];
      if (wb_req.adr == ntm_wb_pkg::ADR_SIZE)
        size_q <= size_wr;
      if (base == ntm_wb_pkg::ADR_A_BASE)
        a_mem[word] <= wb_req.dat[ntm_arith_pkg::DATA_SIZE-1:0];
      if (base == ntm_wb_pkg::ADR_B_BASE)
        b_mem[word] <= wb_req.dat[ntm_arith_pkg::DATA_SIZE-1:0];
    end
  end

  // Result buffer, engine side only
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < ntm_arith_pkg::VECTOR_MAX; i++)
        r_mem[i] <= '0;
    end else if (res_we) begin
      r_mem[res_index] <= res_data;
    end
  end

  //////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////

  always_comb begin
    rd_status               = '0;
    rd_status.status.busy   = busy;
    rd_status.status.done   = done_q;
    rd_data                 = '0;
    case (base)
      ntm_wb_pkg::ADR_A_BASE: rd_data[ntm_arith_pkg::DATA_SIZE-1:0] = a_mem[word];
      ntm_wb_pkg::ADR_B_BASE: rd_data[ntm_arith_pkg::DATA_SIZE-1:0] = b_mem[word];
      ntm_wb_pkg::ADR_R_BASE: rd_data[ntm_arith_pkg::DATA_SIZE-1:0] = r_mem[word];
      default: begin
        // Control region, unmapped words read zero
        if (wb_req.adr == ntm_wb_pkg::ADR_CTRL)
          rd_data = rd_status;
        else if (wb_req.adr == ntm_wb_pkg::ADR_MODULO)
          rd_data[ntm_arith_pkg::DATA_SIZE-1:0] = modulo_q;
        else if (wb_req.adr == ntm_wb_pkg::ADR_SIZE)
          rd_data[ntm_arith_pkg::SIZE_WIDTH-1:0] = size_q;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Handshake, start and done
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wb_rsp <= '0;
      go     <= 1'b0;
      done_q <= 1'b0;
    end else begin
      wb_rsp.ack <= access;
      if (access)
        wb_rsp.dat <= rd_data;
      // Start with empty vector is dropped
      go <= wr_ok & (wb_req.adr == ntm_wb_pkg::ADR_CTRL) & wr_word.ctrl.start
            & (size_q != '0);
      if (go)
        done_q <= 1'b0;
      else if (finish)
        done_q <= 1'b1;
    end
  end

  // Engine view of config and operands
  assign cfg = '{modulo: modulo_q, size: size_q};
  assign op  = '{modulo: modulo_q, a: a_mem[rd_index], b: b_mem[rd_index]};

endmodule

`default_nettype wire

/* source/ntm_vector_ctrl_fsm.sv */
//////////////////////////////////////////////////
// Vector control FSM
// Walks the elements, runs one multiply per element
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module ntm_vector_ctrl_fsm (
  input  wire                                       CLK,
  input  wire                                       RST,
  input  wire                                       go,
  output logic                                      busy,
  output logic                                      finish,
  input  wire ntm_arith_pkg::mul_op_t               op,
  output logic [ntm_arith_pkg::INDEX_SIZE-1:0]      rd_index,
  output logic                                      res_we,
  output logic [ntm_arith_pkg::INDEX_SIZE-1:0]      res_index,
  output logic [ntm_arith_pkg::DATA_SIZE-1:0]       res_data,
  output logic                                      cnt_clear,
  output logic                                      cnt_step,
  input  wire logic [ntm_arith_pkg::INDEX_SIZE-1:0] index,
  input  wire                                       last,
  output logic                                      mul_start,
  output ntm_arith_pkg::mul_op_t                    mul_op,
  input  wire                                       mul_done,
  input  wire logic [ntm_arith_pkg::DATA_SIZE-1:0]  mul_result
);

  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    START,
    WAIT,
    STORE
  } state_t;

  state_t state;

  //////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= IDLE;
      busy     <= 1'b0;
      finish   <= 1'b0;
      mul_op   <= '0;
      res_data <= '0;
    end else begin
      finish <= 1'b0;
      case (state)
        IDLE: begin
          if (go) begin
            busy  <= 1'b1;
            state <= LOAD;
          end
        end
        LOAD: begin
          // Operands at current index
          mul_op <= op;
          state  <= START;
        end
        START: begin
          state <= WAIT;
        end
        WAIT: begin
          if (mul_done) begin
            res_data <= mul_result;
            state    <= STORE;
          end
        end
        STORE: begin
          // Last element ends the run
          if (last) begin
            busy   <= 1'b0;
            finish <= 1'b1;
            state  <= IDLE;
          end else begin
            state <= LOAD;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Counter control
  assign cnt_clear = (state == IDLE) & go;
  assign cnt_step  = (state == STORE) & ~last;

  // Multiplier launch, one cycle
  assign mul_start = (state == START);

  // Buffer access at running index
  assign rd_index  = index;
  assign res_index = index;
  assign res_we    = (state == STORE);

endmodule

`default_nettype wire

/* source/ntm_index_counter.sv */
//////////////////////////////////////////////////
// Element index counter
// Flags the last element of the configured size
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module ntm_index_counter (
  input  wire                                       CLK,
  input  wire                                       RST,
  input  wire                                       clear,
  input  wire                                       step,
  input  wire logic [ntm_arith_pkg::SIZE_WIDTH-1:0] size,
  output logic [ntm_arith_pkg::INDEX_SIZE-1:0]      index,
  output logic                                      last
);

  // Clear wins over step
  always_ff @(posedge CLK or posedge RST) begin
    if (RST)
      index <= '0;
    else if (clear)
      index <= '0;
    else if (step)
      index <= index + 1'b1;
  end

  // Last when index reaches size-1
  assign last = ({1'b0, index} == (size - 1'b1));

endmodule

`default_nettype wire

/* source/ntm_scalar_multiplier.sv */
//////////////////////////////////////////////////
// Scalar modular multiplier
// Bit-serial shift-add, MSB first, two trial
// subtractions per step, done 17 cycles after start
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module ntm_scalar_multiplier (
  input  wire                                  CLK,
  input  wire                                  RST,
  input  wire                                  start,
  input  wire ntm_arith_pkg::mul_op_t          op,
  output logic                                 done,
  output logic [ntm_arith_pkg::DATA_SIZE-1:0]  result
);

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  // Accumulator and latched operands, accumulator width
  logic [ntm_arith_pkg::ACC_SIZE-1:0]      acc;
  logic [ntm_arith_pkg::ACC_SIZE-1:0]      b_q;
  logic [ntm_arith_pkg::ACC_SIZE-1:0]      mod_q;
  // Multiplier bits, MSB consumed first
  logic [ntm_arith_pkg::DATA_SIZE-1:0]     a_sh;
  logic [ntm_arith_pkg::STEP_CNT_SIZE-1:0] bit_cnt;
  logic                                    running;

  // One step of the recurrence
  logic [ntm_arith_pkg::ACC_SIZE-1:0]      sum;
  logic [ntm_arith_pkg::ACC_SIZE-1:0]      red1;
  logic [ntm_arith_pkg::ACC_SIZE-1:0]      red2;

  always_comb begin
    // acc < m, so 2*acc + b < 3*m
    sum = {acc[ntm_arith_pkg::ACC_SIZE-2:0], 1'b0};
    if (a_sh[ntm_arith_pkg::DATA_SIZE-1])
      sum = sum + b_q;
    // Back below m in at most two subtractions
    red1 = (sum >= mod_q) ? sum - mod_q : sum;
    red2 = (red1 >= mod_q) ? red1 - mod_q : red1;
  end

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      running <= 1'b0;
      done    <= 1'b0;
      bit_cnt <= '0;
      acc     <= '0;
      a_sh    <= '0;
      b_q     <= '0;
      mod_q   <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        // Latch operands, 16 steps follow
        running <= 1'b1;
        bit_cnt <= '1;
        acc     <= '0;
        a_sh    <= op.a;
        b_q     <= {2'b00, op.b};
        mod_q   <= {2'b00, op.modulo};
      end else if (running) begin
        acc     <= red2;
        a_sh    <= {a_sh[ntm_arith_pkg::DATA_SIZE-2:0], 1'b0};
        bit_cnt <= bit_cnt - 1'b1;
        // Final step, result valid next cycle
        if (bit_cnt == '0) begin
          running <= 1'b0;
          done    <= 1'b1;
        end
      end
    end
  end

  // Held until next start
  assign result = acc[ntm_arith_pkg::DATA_SIZE-1:0];

endmodule

`default_nettype wire

/* source/ntm_vector_multiplier_top.sv */
//////////////////////////////////////////////////
// Modular vector multiplier top
// Bus block, control FSM, counter, multiplier
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module ntm_vector_multiplier_top (
  input  wire                      CLK,
  input  wire                      RST,
  input  wire ntm_wb_pkg::wb_req_t wb_req,
  output ntm_wb_pkg::wb_rsp_t      wb_rsp
);

  // Register block to engine
  ntm_arith_pkg::vec_cfg_t                 cfg;
  ntm_arith_pkg::mul_op_t                  op;
  logic                                    go;
  logic                                    busy;
  logic                                    finish;
  // Buffer access
  logic [ntm_arith_pkg::INDEX_SIZE-1:0]    rd_index;
  logic                                    res_we;
  logic [ntm_arith_pkg::INDEX_SIZE-1:0]    res_index;
  logic [ntm_arith_pkg::DATA_SIZE-1:0]     res_data;
  // Counter
  logic                                    cnt_clear;
  logic                                    cnt_step;
  logic [ntm_arith_pkg::INDEX_SIZE-1:0]    index;
  logic                                    last;
  // Multiplier
  logic                                    mul_start;
  ntm_arith_pkg::mul_op_t                  mul_op;
  logic                                    mul_done;
  logic [ntm_arith_pkg::DATA_SIZE-1:0]     mul_result;

  ntm_wb_regs u_regs (
    .CLK       (CLK),
    .RST       (RST),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .cfg       (cfg),
    .go        (go),
    .busy      (busy),
    .finish    (finish),
    .rd_index  (rd_index),
    .op        (op),
    .res_we    (res_we),
    .res_index (res_index),
    .res_data  (res_data)
  );

  ntm_vector_ctrl_fsm u_fsm (
    .CLK        (CLK),
    .RST        (RST),
    .go         (go),
    .busy       (busy),
    .finish     (finish),
    .op         (op),
    .rd_index   (rd_index),
    .res_we     (res_we),
    .res_index  (res_index),
    .res_data   (res_data),
    .cnt_clear  (cnt_clear),
    .cnt_step   (cnt_step),
    .index      (index),
    .last       (last),
    .mul_start  (mul_start),
    .mul_op     (mul_op),
    .mul_done   (mul_done),
    .mul_result (mul_result)
  );

  // Size only, modulo travels with the operands
  ntm_index_counter u_counter (
    .CLK   (CLK),
    .RST   (RST),
    .clear (cnt_clear),
    .step  (cnt_step),
    .size  (cfg.size),
    .index (index),
    .last  (last)
  );

  ntm_scalar_multiplier u_mul (
    .CLK    (CLK),
    .RST    (RST),
    .start  (mul_start),
    .op     (mul_op),
    .done   (mul_done),
    .result (mul_result)
  );

endmodule

`default_nettype wire

/* tests/tb_ntm_vector_multiplier.sv */
//////////////////////////////////////////////////
// Testbench of the modular vector multiplier
// Wishbone host model, LFSR operands, checked runs
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_ntm_vector_multiplier;

  // Handshake and status poll limits
  localparam int ACK_LIMIT  = 20;
  localparam int POLL_LIMIT = 500;
  localparam int DEPTH      = ntm_arith_pkg::VECTOR_MAX;

  logic                CLK;
  logic                RST;
  ntm_wb_pkg::wb_req_t wb_req;
  ntm_wb_pkg::wb_rsp_t wb_rsp;

  // Random source and score
  logic [31:0] lfsr_state;
  int          pass_count;
  int          fail_count;
  int          test_fail_base;

  // Host copy of operands, expected result buffer
  logic [31:0] op_a [DEPTH];
  logic [31:0] op_b [DEPTH];
  logic [31:0] model_r [DEPTH];
  logic [31:0] modulo;

  ntm_vector_multiplier_top DUT (
    .CLK    (CLK),
    .RST    (RST),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  // 100 ns clock
  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  //////////////////////////////////////////////////
  // Random numbers and reference model
  //////////////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One step per bit taken
  function automatic logic [31:0] draw_bits(input int nbits);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
    return val;
  endfunction

  // Product of two 16-bit operands fits in 32 bits
  function automatic logic [31:0] mod_mul(input logic [31:0] a, input logic [31:0] b,
                                          input logic [31:0] m);
    return (a * b) % m;
  endfunction

  //////////////////////////////////////////////////
  // Bus master
  //////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("Timeout: %s at %0t ns", why, $time);
    $display("Some tests failed");
    $finish;
  endtask

  task automatic wb_write(input logic [5:0] addr, input logic [31:0] wdata);
    int waited;
    @(posedge CLK);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: addr, dat: wdata};
    // Ack sampled mid cycle
    waited = 0;
    do begin
      @(negedge CLK);
      waited++;
    end while (!wb_rsp.ack && waited < ACK_LIMIT);
    if (!wb_rsp.ack)
      abort_run("the slave never acked a write");
    @(posedge CLK);
    wb_req <= '0;
  endtask

  task automatic wb_read(input logic [5:0] addr, output logic [31:0] rdata);
    int waited;
    @(posedge CLK);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: addr, dat: 32'h0};
    waited = 0;
    do begin
      @(negedge CLK);
      waited++;
    end while (!wb_rsp.ack && waited < ACK_LIMIT);
    if (!wb_rsp.ack)
      abort_run("the slave never acked a read");
    // Data valid with ack
    rdata = wb_rsp.dat;
    @(posedge CLK);
    wb_req <= '0;
  endtask

  // Poll status until done
  task automatic wait_done();
    ntm_wb_pkg::ctrl_word_u word;
    int polls;
    polls = 0;
    do begin
      wb_read(ntm_wb_pkg::ADR_CTRL, word);
      polls++;
    end while (!word.status.done && polls < POLL_LIMIT);
    if (!word.status.done)
      abort_run("the done bit never came up");
  endtask

  //////////////////////////////////////////////////
  // Checks and test helpers
  //////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got == exp) begin
      pass_count++;
    end else begin
      $display("[FAIL] %0t ns: %s read 0x%0h, expected 0x%0h", $time, what, got, exp);
      fail_count++;
    end
  endtask

  task automatic end_test(input string name);
    $display("Test %s finished with %0d errors", name, fail_count - test_fail_base);
    test_fail_base = fail_count;
  endtask

  // Operands kept below the modulo
  task automatic fill_operands(input int n);
    for (int i = 0; i < n; i++) begin
      op_a[i] = draw_bits(16) % modulo;
      op_b[i] = draw_bits(16) % modulo;
    end
  endtask

  task automatic write_operands(input int n);
    for (int i = 0; i < n; i++) begin
      wb_write(ntm_wb_pkg::ADR_A_BASE + 6'(i), op_a[i]);
      wb_write(ntm_wb_pkg::ADR_B_BASE + 6'(i), op_b[i]);
    end
  endtask

  // Only the first n words change in a run
  task automatic update_model(input int n);
    for (int i = 0; i < n; i++)
      model_r[i] = mod_mul(op_a[i], op_b[i], modulo);
  endtask

  task automatic check_results();
    logic [31:0] rdata;
    for (int i = 0; i < DEPTH; i++) begin
      wb_read(ntm_wb_pkg::ADR_R_BASE + 6'(i), rdata);
      check_value($sformatf("result word %0d", i), rdata, model_r[i]);
    end
  endtask

  // Start, wait, then expect done=1 busy=0
  task automatic run_engine(input int n);
    logic [31:0] rdata;
    wb_write(ntm_wb_pkg::ADR_CTRL, 32'h1);
    wait_done();
    wb_read(ntm_wb_pkg::ADR_CTRL, rdata);
    check_value("status after run", rdata, 32'h2);
    update_model(n);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    logic [31:0] rdata;
    lfsr_state     = 32'd97837;
    pass_count     = 0;
    fail_count     = 0;
    test_fail_base = 0;
    RST            = 1'b1;
    wb_req         = '0;
    repeat (3) @(posedge CLK);
    RST <= 1'b0;

    // Idle status, cleared result buffer
    wb_read(ntm_wb_pkg::ADR_CTRL, rdata);
    check_value("status after reset", rdata, 32'h0);
    for (int i = 0; i < DEPTH; i++)
      model_r[i] = 32'h0;
    check_results();
    end_test("reset state");

    // Register and buffer readback
    modulo = draw_bits(16);
    if (modulo < 2)
      modulo = modulo + 2;
    fill_operands(DEPTH);
    wb_write(ntm_wb_pkg::ADR_MODULO, modulo);
    wb_write(ntm_wb_pkg::ADR_SIZE, 32'd16);
    write_operands(DEPTH);
    wb_read(ntm_wb_pkg::ADR_MODULO, rdata);
    check_value("modulo", rdata, modulo);
    wb_read(ntm_wb_pkg::ADR_SIZE, rdata);
    check_value("size", rdata, 32'd16);
    for (int i = 0; i < DEPTH; i++) begin
      wb_read(ntm_wb_pkg::ADR_A_BASE + 6'(i), rdata);
      check_value($sformatf("A word %0d", i), rdata, op_a[i]);
      wb_read(ntm_wb_pkg::ADR_B_BASE + 6'(i), rdata);
      check_value($sformatf("B word %0d", i), rdata, op_b[i]);
    end
    end_test("register readback");

    // Full vector with the operands above
    run_engine(DEPTH);
    check_results();
    end_test("full run");

    // Short vector, new operands in every word, upper results untouched
    fill_operands(DEPTH);
    write_operands(DEPTH);
    wb_write(ntm_wb_pkg::ADR_SIZE, 32'd3);
    run_engine(3);
    check_results();
    end_test("size 3 run");

    // (-1)*(-1) mod 65535
    modulo  = 32'd65535;
    op_a[0] = 32'd65534;
    op_b[0] = 32'd65534;
    wb_write(ntm_wb_pkg::ADR_MODULO, modulo);
    wb_write(ntm_wb_pkg::ADR_SIZE, 32'd1);
    write_operands(1);
    run_engine(1);
    wb_read(ntm_wb_pkg::ADR_R_BASE, rdata);
    check_value("65534*65534 mod 65535", rdata, 32'd1);
    // Modulo 1, every result zero
    modulo = 32'd1;
    for (int i = 0; i < DEPTH; i++) begin
      op_a[i] = 32'h0;
      op_b[i] = 32'h0;
    end
    wb_write(ntm_wb_pkg::ADR_MODULO, modulo);
    wb_write(ntm_wb_pkg::ADR_SIZE, 32'd16);
    write_operands(DEPTH);
    run_engine(DEPTH);
    check_results();
    end_test("edge moduli");

    // Writes during a run are dropped
    modulo = draw_bits(16) | 32'h2;
    fill_operands(DEPTH);
    wb_write(ntm_wb_pkg::ADR_MODULO, modulo);
    write_operands(DEPTH);
    wb_write(ntm_wb_pkg::ADR_CTRL, 32'h1);
    wb_read(ntm_wb_pkg::ADR_CTRL, rdata);
    check_value("status while running", rdata, 32'h1);
    wb_write(ntm_wb_pkg::ADR_A_BASE + 6'd5, ~op_a[5] & 32'hFFFF);
    wb_write(ntm_wb_pkg::ADR_MODULO, modulo ^ 32'h1);
    wb_write(ntm_wb_pkg::ADR_CTRL, 32'h1);
    wait_done();
    wb_read(ntm_wb_pkg::ADR_CTRL, rdata);
    check_value("status after run", rdata, 32'h2);
    update_model(DEPTH);
    check_results();
    wb_read(ntm_wb_pkg::ADR_A_BASE + 6'd5, rdata);
    check_value("A word 5 after busy write", rdata, op_a[5]);
    wb_read(ntm_wb_pkg::ADR_MODULO, rdata);
    check_value("modulo after busy write", rdata, modulo);
    end_test("busy lockout");

    $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* ntm_vector_multiplier_top.f */
source/ntm_arith_pkg.sv
source/ntm_wb_pkg.sv
source/ntm_wb_regs.sv
source/ntm_vector_ctrl_fsm.sv
source/ntm_index_counter.sv
source/ntm_scalar_multiplier.sv
source/ntm_vector_multiplier_top.sv
tests/tb_ntm_vector_multiplier.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --top-module tb_ntm_vector_multiplier \
  -f ntm_vector_multiplier_top.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -q "All tests passed" sim.log \
  && echo "Simulation PASS" \
  || { echo "Simulation FAIL"; exit 1; }
